// ==== jtframe_mist.f ====
common/jtframe_pkg.sv
base/jtframe_spi_rx.sv
base/jtframe_io_cmd.sv
board/jtframe_prog_pack.sv
board/jtframe_rom_port.sv
board/jtframe_board_ctrl.sv
source/jtframe_mist.sv
sim/jtframe_mist_tb.sv

// ==== sim/jtframe_mist_tb.sv ====
`timescale 1ns/1ps

module jtframe_mist_tb import jtframe_pkg::*; ();

localparam int DL_BYTES = 37;
localparam int DL_WORDS = (DL_BYTES + 1) / 2;
// Status 2x5, joysticks 2x3, download 1+38+1, blocked read 1+1
localparam int SPI_BYTES      = 58;
localparam int TIMEOUT_CYCLES = SPI_BYTES * 100 + 2000;

logic        clk_sys;
logic        arst_n;
logic        SPI_SCK, SPI_DI, SPI_SS2;
logic        rst_req;
logic        ba_rd;
logic [9:0]  ba_addr;
logic [31:0] status;
logic        downloading;
logic        rst, game_rst, game_rst_n;
logic        dip_pause, dip_flip, dip_test;
logic [1:0]  dip_fxlevel;
logic [7:0]  dipsw;
logic [9:0]  game_joystick1, game_joystick2;
logic [1:0]  game_coin, game_start;
logic        ba_ack, ba_dok;
logic [15:0] sdram_dout;

logic [31:0] lfsr_state;
logic [7:0]  frame_buf [0:63];
logic [7:0]  dl_bytes [0:DL_BYTES-1];
int          cycle_cnt;

jtframe_mist #(
    .BUTTONS               ( 2     ),
    .GAME_INPUTS_ACTIVE_LOW( 1'b1  ),
    .DIPBASE               ( 16    ),
    .ROMW                  ( 10    )
) jtframe_mist_inst(.*);

initial begin
    clk_sys = 1'b0;
    forever #4 clk_sys = ~clk_sys;
end

task automatic stop_run();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first failure");
endtask

initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
        @(posedge clk_sys);
        cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    stop_run();
end

// Galois form, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
endfunction

task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("[ERROR] %s got %h expected %h", name, got, exp);
        stop_run();
    end
endtask

task automatic check_pair(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
        $display("[ERROR] %s got %h expected %h", name, got, exp);
        stop_run();
    end
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
        $display("[ERROR] %s got %h expected %h", name, got, exp);
        stop_run();
    end
endtask

task automatic check_joy(input string name, input logic [9:0] got, input logic [9:0] exp);
    if (got !== exp) begin
        $display("[ERROR] %s got %h expected %h", name, got, exp);
        stop_run();
    end
endtask

task automatic check_word16(input string name, input logic [15:0] got,
                            input logic [15:0] exp);
    if (got !== exp) begin
        $display("[ERROR] %s got %h expected %h", name, got, exp);
        stop_run();
    end
endtask

task automatic check_status(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
        $display("[ERROR] %s got %h expected %h", name, got, exp);
        stop_run();
    end
endtask

// Mode 0, data changes with SCK low, 5 cycle half period
task automatic spi_send_frame(input int len);
    SPI_SS2 = 1'b0;
    repeat (5) @(negedge clk_sys);
    for (int b = 0; b < len; b++) begin
        for (int i = 7; i >= 0; i--) begin
            SPI_DI = frame_buf[b][i];
            repeat (5) @(negedge clk_sys);
            SPI_SCK = 1'b1;
            repeat (5) @(negedge clk_sys);
            SPI_SCK = 1'b0;
        end
    end
    repeat (5) @(negedge clk_sys);
    SPI_SS2 = 1'b1;
    repeat (8) @(negedge clk_sys);
endtask

task automatic send_opcode(input io_op_e op);
    frame_buf[0] = op;
    spi_send_frame(1);
endtask

task automatic send_status(input logic [31:0] st);
    frame_buf[0] = OP_STATUS;
    for (int i = 0; i < 4; i++) begin
        frame_buf[i+1] = st[8*i +: 8];
    end
    spi_send_frame(5);
endtask

// Waits for the ack, drops the request and collects the data at dok
task automatic finish_read(output logic [15:0] data);
    int delay;
    @(negedge clk_sys);
    while (!ba_ack) @(negedge clk_sys);
    ba_rd = 1'b0;
    @(negedge clk_sys);
    delay = 1;
    while (!ba_dok) begin
        @(negedge clk_sys);
        delay++;
    end
    if (delay != 2) begin
        $display("ba_dok came %0d cycles after ba_ack instead of 2", delay);
        stop_run();
    end
    data = sdram_dout;
endtask

task automatic read_word(input int addr, output logic [15:0] data);
    ba_addr = 10'(addr);
    ba_rd   = 1'b1;
    finish_read(data);
endtask

// Low byte first, an odd last byte gets a zero high byte
function automatic logic [15:0] expected_word(input int i);
    if (2*i + 1 < DL_BYTES) begin
        return {dl_bytes[2*i+1], dl_bytes[2*i]};
    end
    return {8'h00, dl_bytes[2*i]};
endfunction

task automatic test_reset_state();
    check_bit("rst", rst, 1'b1);
    check_bit("game_rst", game_rst, 1'b1);
    check_bit("game_rst_n", game_rst_n, 1'b0);
    check_bit("ba_ack", ba_ack, 1'b0);
    check_bit("ba_dok", ba_dok, 1'b0);
    check_bit("downloading", downloading, 1'b0);
    check_status("status", status, 32'h0);
    check_joy("game_joystick1", game_joystick1, 10'h3FF);
    check_joy("game_joystick2", game_joystick2, 10'h3FF);
    check_pair("game_coin", game_coin, 2'b11);
    check_pair("game_start", game_start, 2'b11);
    check_byte("dipsw", dipsw, 8'h00);
    while (game_rst) @(negedge clk_sys);
    check_bit("game_rst_n", game_rst_n, 1'b1);
    check_bit("rst", rst, 1'b0);
endtask

task automatic test_status_write();
    logic [31:0] st;
    take_bits(32, st);
    // Request a game reset through bit 0
    st[0] = 1'b1;
    send_status(st);
    check_status("status", status, st);
    check_bit("dip_pause", dip_pause, st[1]);
    check_bit("dip_flip", dip_flip, st[2]);
    check_bit("dip_test", dip_test, st[5]);
    check_pair("dip_fxlevel", dip_fxlevel, st[4:3]);
    check_byte("dipsw", dipsw, st[23:16]);
    check_bit("game_rst", game_rst, st[0]);
    // Clear the reset request bit again
    st[0] = 1'b0;
    send_status(st);
    check_status("status", status, st);
    while (game_rst) @(negedge clk_sys);
endtask

task automatic test_joystick_map();
    logic [31:0] w1, w2;
    take_bits(16, w1);
    take_bits(16, w2);
    frame_buf[0] = OP_JOY1;
    frame_buf[1] = w1[7:0];
    frame_buf[2] = w1[15:8];
    spi_send_frame(3);
    frame_buf[0] = OP_JOY2;
    frame_buf[1] = w2[7:0];
    frame_buf[2] = w2[15:8];
    spi_send_frame(3);
    // Two buttons in use, the rest idle high
    check_joy("game_joystick1", game_joystick1, {4'hF, ~w1[5:4], ~w1[3:0]});
    check_joy("game_joystick2", game_joystick2, {4'hF, ~w2[5:4], ~w2[3:0]});
    check_pair("game_coin", game_coin, ~{w2[11], w1[11]});
    check_pair("game_start", game_start, ~{w2[10], w1[10]});
endtask

task automatic test_download();
    logic [31:0] v;
    logic [15:0] got;
    send_opcode(OP_DL_START);
    check_bit("downloading", downloading, 1'b1);
    frame_buf[0] = OP_DL_DATA;
    for (int i = 0; i < DL_BYTES; i++) begin
        take_bits(8, v);
        dl_bytes[i]    = v[7:0];
        frame_buf[i+1] = v[7:0];
    end
    spi_send_frame(DL_BYTES + 1);
    check_bit("downloading", downloading, 1'b1);
    send_opcode(OP_DL_END);
    check_bit("downloading", downloading, 1'b0);
    for (int i = 0; i < DL_WORDS; i++) begin
        read_word(i, got);
        check_word16("sdram_dout", got, expected_word(i));
    end
endtask

task automatic test_blocked_read();
    logic [15:0] got;
    send_opcode(OP_DL_START);
    ba_addr = 10'd5;
    ba_rd   = 1'b1;
    repeat (200) begin
        @(negedge clk_sys);
        check_bit("ba_ack", ba_ack, 1'b0);
    end
    frame_buf[0] = OP_DL_END;
    fork
        spi_send_frame(1);
        finish_read(got);
    join
    check_word16("sdram_dout", got, expected_word(5));
endtask

task automatic test_reset_request();
    int cnt;
    while (game_rst) @(negedge clk_sys);
    rst_req = 1'b1;
    repeat (3) @(negedge clk_sys);
    rst_req = 1'b0;
    check_bit("game_rst", game_rst, 1'b1);
    cnt = 0;
    while (game_rst && cnt <= GAME_RST_HOLD + 1) begin
        @(negedge clk_sys);
        cnt++;
    end
    if (game_rst || cnt != GAME_RST_HOLD + 1) begin
        $display("game_rst fell %0d cycles after rst_req dropped instead of %0d",
                 cnt, GAME_RST_HOLD + 1);
        stop_run();
    end
    check_bit("game_rst_n", game_rst_n, 1'b1);
endtask

initial begin
    arst_n     = 1'b0;
    SPI_SCK    = 1'b0;
    SPI_DI     = 1'b0;
    SPI_SS2    = 1'b1;
    rst_req    = 1'b0;
    ba_rd      = 1'b0;
    ba_addr    = '0;
    lfsr_state = 32'h2eb1115d;
    repeat (8) @(negedge clk_sys);
    arst_n = 1'b1;
    test_reset_state();
    test_status_write();
    test_joystick_map();
    test_download();
    test_blocked_read();
    test_reset_request();
    $display("RESULT: PASS");
    $finish;
end

endmodule

// ==== source/jtframe_mist.sv ====
`timescale 1ns/1ps

module jtframe_mist import jtframe_pkg::*; #(
    parameter int BUTTONS                = 2,
    parameter bit GAME_INPUTS_ACTIVE_LOW = 1'b1,
    parameter int DIPBASE                = 16,
    parameter int ROMW                   = 10
)(
    input  logic            clk_sys,
    input  logic            arst_n,
    // SPI from the I/O controller
    input  logic            SPI_SCK,
    input  logic            SPI_DI,
    input  logic            SPI_SS2,
    output logic [31:0]     status,
    output logic            downloading,
    // Resets
    input  logic            rst_req,
    output logic            rst,
    output logic            game_rst,
    output logic            game_rst_n,
    // DIP and OSD settings
    output logic            dip_pause,
    output logic            dip_flip,
    output logic            dip_test,
    output logic [1:0]      dip_fxlevel,
    output logic [7:0]      dipsw,
    // Game inputs
    output logic [9:0]      game_joystick1,
    output logic [9:0]      game_joystick2,
    output logic [1:0]      game_coin,
    output logic [1:0]      game_start,
    // ROM reads from the game
    input  logic            ba_rd,
    input  logic [ROMW-1:0] ba_addr,
    output logic            ba_ack,
    output logic            ba_dok,
    output logic [15:0]     sdram_dout
);

spi_evt_t  spi_evt;
joy_word_t joy1, joy2;
dl_evt_t   dl_evt;
wb_req_t   wb_req;
wb_rsp_t   wb_rsp;

jtframe_spi_rx u_spi(
    .clk_sys    ( clk_sys     ),
    .arst_n     ( arst_n      ),
    .SPI_SCK    ( SPI_SCK     ),
    .SPI_DI     ( SPI_DI      ),
    .SPI_SS2    ( SPI_SS2     ),
    .spi_evt    ( spi_evt     )
);

jtframe_io_cmd u_cmd(
    .clk_sys    ( clk_sys     ),
    .arst_n     ( arst_n      ),
    .spi_evt    ( spi_evt     ),
    .status     ( status      ),
    .joy1       ( joy1        ),
    .joy2       ( joy2        ),
    .dl_evt     ( dl_evt      ),
    .downloading( downloading )
);

jtframe_prog_pack #(.ROMW( ROMW )) u_pack(
    .clk_sys    ( clk_sys     ),
    .arst_n     ( arst_n      ),
    .dl_evt     ( dl_evt      ),
    .wb_rsp     ( wb_rsp      ),
    .wb_req     ( wb_req      )
);

jtframe_rom_port #(.ROMW( ROMW )) u_rom(
    .clk_sys    ( clk_sys     ),
    .arst_n     ( arst_n      ),
    .wb_req     ( wb_req      ),
    .wb_rsp     ( wb_rsp      ),
    .downloading( downloading ),
    .ba_rd      ( ba_rd       ),
    .ba_addr    ( ba_addr     ),
    .ba_ack     ( ba_ack      ),
    .ba_dok     ( ba_dok      ),
    .sdram_dout ( sdram_dout  )
);

jtframe_board_ctrl #(
    .BUTTONS               ( BUTTONS                ),
    .GAME_INPUTS_ACTIVE_LOW( GAME_INPUTS_ACTIVE_LOW ),
    .DIPBASE               ( DIPBASE                )
) u_board(
    .clk_sys        ( clk_sys        ),
    .arst_n         ( arst_n         ),
    .status         ( status         ),
    .joy1           ( joy1           ),
    .joy2           ( joy2           ),
    .downloading    ( downloading    ),
    .rst_req        ( rst_req        ),
    .rst            ( rst            ),
    .game_rst       ( game_rst       ),
    .game_rst_n     ( game_rst_n     ),
    .dip_pause      ( dip_pause      ),
    .dip_flip       ( dip_flip       ),
    .dip_test       ( dip_test       ),
    .dip_fxlevel    ( dip_fxlevel    ),
    .dipsw          ( dipsw          ),
    .game_joystick1 ( game_joystick1 ),
    .game_joystick2 ( game_joystick2 ),
    .game_coin      ( game_coin      ),
    .game_start     ( game_start     )
);

endmodule

// ==== board/jtframe_board_ctrl.sv ====
`timescale 1ns/1ps

module jtframe_board_ctrl import jtframe_pkg::*; #(
    parameter int BUTTONS                = 2,
    parameter bit GAME_INPUTS_ACTIVE_LOW = 1'b1,
    parameter int DIPBASE                = 16
)(
    input  logic        clk_sys,
    input  logic        arst_n,
    input  logic [31:0] status,
    input  joy_word_t   joy1,
    input  joy_word_t   joy2,
    input  logic        downloading,
    input  logic        rst_req,
    output logic        rst,
    output logic        game_rst,
    output logic        game_rst_n,
    output logic        dip_pause,
    output logic        dip_flip,
    output logic        dip_test,
    output logic [1:0]  dip_fxlevel,
    output logic [7:0]  dipsw,
    output logic [9:0]  game_joystick1,
    output logic [9:0]  game_joystick2,
    output logic [1:0]  game_coin,
    output logic [1:0]  game_start
);

localparam int         HOLD_W   = $clog2(GAME_RST_HOLD + 1);
localparam logic [5:0] BTN_MASK = 6'((1 << BUTTONS) - 1);
localparam logic [9:0] INV      = {10{GAME_INPUTS_ACTIVE_LOW}};

logic [1:0]        rst_sync;
logic [HOLD_W-1:0] hold_cnt;
logic              rst_cause;

function automatic logic [9:0] map_joy(joy_word_t j);
    return INV ^ {j.buttons & BTN_MASK, j.up, j.down, j.left, j.right};
endfunction

assign rst        = rst_sync[1];
assign rst_cause  = rst | downloading | rst_req | status[ST_RST];
assign game_rst_n = ~game_rst;

always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
        rst_sync <= 2'b11;
        hold_cnt <= HOLD_W'(GAME_RST_HOLD);
        game_rst <= 1'b1;
    end else begin
        rst_sync <= {rst_sync[0], 1'b0};
        if (rst_cause) begin
            hold_cnt <= HOLD_W'(GAME_RST_HOLD);
            game_rst <= 1'b1;
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end else begin
            game_rst <= 1'b0;
        end
    end
end

// Settings and inputs seen by the game
always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
        dip_pause      <= 1'b0;
        dip_flip       <= 1'b0;
        dip_test       <= 1'b0;
        dip_fxlevel    <= 2'd0;
        dipsw          <= 8'd0;
        game_joystick1 <= INV;
        game_joystick2 <= INV;
        game_coin      <= INV[1:0];
        game_start     <= INV[1:0];
    end else begin
        dip_pause      <= status[ST_PAUSE];
        dip_flip       <= status[ST_FLIP];
        dip_test       <= status[ST_TEST];
        dip_fxlevel    <= status[4:3];
        dipsw          <= status[DIPBASE +: 8];
        game_joystick1 <= map_joy(joy1);
        game_joystick2 <= map_joy(joy2);
        game_coin      <= INV[1:0] ^ {joy2.coin, joy1.coin};
        game_start     <= INV[1:0] ^ {joy2.start, joy1.start};
    end
end

endmodule

// ==== board/jtframe_rom_port.sv ====
`timescale 1ns/1ps

module jtframe_rom_port import jtframe_pkg::*; #(
    parameter int ROMW = 10
)(
    input  logic            clk_sys,
    input  logic            arst_n,
    input  wb_req_t         wb_req,
    output wb_rsp_t         wb_rsp,
    input  logic            downloading,
    input  logic            ba_rd,
    input  logic [ROMW-1:0] ba_addr,
    output logic            ba_ack,
    output logic            ba_dok,
    output logic [15:0]     sdram_dout
);

logic [15:0]     mem [2**ROMW];
logic [ROMW-1:0] rd_addr;
logic [15:0]     rd_data;
logic            wb_ack;
logic            rd_s1;
logic            wr_en, rd_take;

// Store starts out cleared
initial begin
    for (int i = 0; i < 2**ROMW; i++) begin
        mem[i] = '0;
    end
end

assign wr_en   = wb_req.cyc & wb_req.stb & wb_req.we & ~wb_ack;
// Writes take the cycle, one read in flight at a time
assign rd_take = ba_rd & ~downloading & ~wr_en & ~ba_ack & ~rd_s1;

always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
        wb_ack <= 1'b0;
        ba_ack <= 1'b0;
        rd_s1  <= 1'b0;
        ba_dok <= 1'b0;
    end else begin
        wb_ack <= wb_req.cyc & wb_req.stb & ~wb_ack;
        ba_ack <= rd_take;
        rd_s1  <= ba_ack;
        ba_dok <= rd_s1;
    end
end

// Byte lane writes
always_ff @(posedge clk_sys) begin
    if (wr_en && wb_req.sel[0]) begin
        mem[wb_req.adr[ROMW-1:0]][7:0] <= wb_req.dat[7:0];
    end
    if (wr_en && wb_req.sel[1]) begin
        mem[wb_req.adr[ROMW-1:0]][15:8] <= wb_req.dat[15:8];
    end
end

// Two stage read, array then output register
always_ff @(posedge clk_sys) begin
    if (rd_take) begin
        rd_addr <= ba_addr;
    end
    if (ba_ack) begin
        rd_data <= mem[rd_addr];
    end
    if (rd_s1) begin
        sdram_dout <= rd_data;
    end
end

assign wb_rsp = '{ack: wb_ack, dat: rd_data};

endmodule

// ==== board/jtframe_prog_pack.sv ====
`timescale 1ns/1ps

module jtframe_prog_pack import jtframe_pkg::*; #(
    parameter int ROMW = 10
)(
    input  logic    clk_sys,
    input  logic    arst_n,
    input  dl_evt_t dl_evt,
    input  wb_rsp_t wb_rsp,
    output wb_req_t wb_req
);

logic [7:0]      lo_buf;
logic            lo_full;
logic [ROMW-1:0] waddr;
logic [ROMW-1:0] wadr;
logic [15:0]     wdat;
logic [1:0]      wsel;
logic            stb;
logic            take_lo, take_hi, flush;

assign take_lo = dl_evt.valid & ~lo_full;
assign take_hi = dl_evt.valid & lo_full;
// Odd byte count leaves a low byte behind at stop
assign flush   = dl_evt.stop & lo_full;

always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
        lo_full <= 1'b0;
        waddr   <= '0;
        stb     <= 1'b0;
    end else begin
        if (stb && wb_rsp.ack) begin
            stb <= 1'b0;
        end
        if (dl_evt.start) begin
            lo_full <= 1'b0;
            waddr   <= '0;
        end else if (take_lo) begin
            lo_full <= 1'b1;
        end else if (take_hi || flush) begin
            lo_full <= 1'b0;
            stb     <= 1'b1;
            // Wraps past the top of the ROM
            waddr   <= waddr + 1'b1;
        end
    end
end

always_ff @(posedge clk_sys) begin
    if (take_lo) begin
        lo_buf <= dl_evt.data;
    end
    if (take_hi || flush) begin
        wadr <= waddr;
        wdat <= take_hi ? {dl_evt.data, lo_buf} : {8'h00, lo_buf};
        wsel <= take_hi ? 2'b11 : 2'b01;
    end
end

assign wb_req = '{cyc: stb, stb: stb, we: 1'b1, adr: ROMW_MAX'(wadr),
                  dat: wdat, sel: wsel};

endmodule

// ==== base/jtframe_io_cmd.sv ====
`timescale 1ns/1ps

module jtframe_io_cmd import jtframe_pkg::*; (
    input  logic        clk_sys,
    input  logic        arst_n,
    input  spi_evt_t    spi_evt,
    output logic [31:0] status,
    output joy_word_t   joy1,
    output joy_word_t   joy2,
    output dl_evt_t     dl_evt,
    output logic        downloading
);

cmd_state_e  state;
io_op_e      op;
logic [1:0]  cnt;
logic        joy_sel;
logic [23:0] lanes;

assign op = io_op_e'(spi_evt.data);

always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
        state       <= CMD_IDLE;
        cnt         <= 2'd0;
        joy_sel     <= 1'b0;
        status      <= 32'd0;
        joy1        <= '0;
        joy2        <= '0;
        dl_evt      <= '0;
        downloading <= 1'b0;
    end else begin
        dl_evt <= '0;
        if (spi_evt.frame_end) begin
            state <= CMD_IDLE;
        end else if (spi_evt.byte_valid) begin
            case (state)
                CMD_IDLE: begin
                    cnt <= 2'd0;
                    case (op)
                        OP_STATUS: state <= CMD_STATUS;
                        OP_JOY1, OP_JOY2: begin
                            state   <= CMD_JOY;
                            joy_sel <= (op == OP_JOY2);
                        end
                        OP_DL_START: begin
                            dl_evt.start <= 1'b1;
                            downloading  <= 1'b1;
                            state        <= CMD_SKIP;
                        end
                        OP_DL_DATA: state <= CMD_DATA;
                        OP_DL_END: begin
                            dl_evt.stop <= 1'b1;
                            downloading <= 1'b0;
                            state       <= CMD_SKIP;
                        end
                        default: state <= CMD_SKIP;
                    endcase
                end
                CMD_STATUS: begin
                    cnt <= cnt + 2'd1;
                    if (cnt == 2'd3) begin
                        status <= {spi_evt.data, lanes};
                        state  <= CMD_SKIP;
                    end
                end
                CMD_JOY: begin
                    cnt <= cnt + 2'd1;
                    if (cnt == 2'd1) begin
                        if (joy_sel) begin
                            joy2 <= joy_word_t'({spi_evt.data, lanes[7:0]});
                        end else begin
                            joy1 <= joy_word_t'({spi_evt.data, lanes[7:0]});
                        end
                        state <= CMD_SKIP;
                    end
                end
                CMD_DATA: begin
                    dl_evt.data  <= spi_evt.data;
                    dl_evt.valid <= 1'b1;
                end
                default: ;
            endcase
        end
    end
end

// Payload bytes, least significant first
always_ff @(posedge clk_sys) begin
    if (spi_evt.byte_valid && (state == CMD_STATUS || state == CMD_JOY)) begin
        lanes[8*cnt +: 8] <= spi_evt.data;
    end
end

endmodule

// ==== base/jtframe_spi_rx.sv ====
`timescale 1ns/1ps

module jtframe_spi_rx import jtframe_pkg::*; (
    input  logic     clk_sys,
    input  logic     arst_n,
    input  logic     SPI_SCK,
    input  logic     SPI_DI,
    input  logic     SPI_SS2,
    output spi_evt_t spi_evt
);

logic [1:0] sck_sync, di_sync, ss_sync;
logic       sck_last, ss_last;
logic       sck_rise;
logic [2:0] bit_cnt;
logic [6:0] shreg;

assign sck_rise = sck_sync[1] & ~sck_last;

// Pin synchronizers, select idles high
always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
        sck_sync <= 2'b00;
        di_sync  <= 2'b00;
        ss_sync  <= 2'b11;
        sck_last <= 1'b0;
        ss_last  <= 1'b1;
    end else begin
        sck_sync <= {sck_sync[0], SPI_SCK};
        di_sync  <= {di_sync[0], SPI_DI};
        ss_sync  <= {ss_sync[0], SPI_SS2};
        sck_last <= sck_sync[1];
        ss_last  <= ss_sync[1];
    end
end

always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
        bit_cnt <= 3'd0;
        spi_evt <= '0;
    end else begin
        spi_evt.byte_valid <= 1'b0;
        spi_evt.frame_end  <= ss_sync[1] & ~ss_last;
        if (ss_sync[1]) begin
            bit_cnt <= 3'd0;
        end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            // Eighth bit completes the byte
            if (bit_cnt == 3'd7) begin
                spi_evt.data       <= {shreg, di_sync[1]};
                spi_evt.byte_valid <= 1'b1;
            end
        end
    end
end

// MSB first
always_ff @(posedge clk_sys) begin
    if (sck_rise) begin
        shreg <= {shreg[5:0], di_sync[1]};
    end
end

endmodule

// ==== common/jtframe_pkg.sv ====
package jtframe_pkg;

    localparam int ROMW_MAX      = 16;
    localparam int GAME_RST_HOLD = 16;

    // Status word bit positions
    localparam int ST_RST   = 0;
    localparam int ST_PAUSE = 1;
    localparam int ST_FLIP  = 2;
    localparam int ST_TEST  = 5;

    typedef struct packed {
        logic [7:0] data;
        logic       byte_valid;
        logic       frame_end;
    } spi_evt_t;

    // First byte of every SPI frame
    typedef enum logic [7:0] {
        OP_JOY1     = 8'h02,
        OP_JOY2     = 8'h03,
        OP_STATUS   = 8'h1E,
        OP_DL_START = 8'h55,
        OP_DL_DATA  = 8'h56,
        OP_DL_END   = 8'h57
    } io_op_e;

    typedef enum logic [2:0] {
        CMD_IDLE,
        CMD_STATUS,
        CMD_JOY,
        CMD_DATA,
        CMD_SKIP
    } cmd_state_e;

    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       start;
        logic       stop;
    } dl_evt_t;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [ROMW_MAX-1:0] adr;
        logic [15:0]         dat;
        logic [1:0]          sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] dat;
    } wb_rsp_t;

    // Board joystick, active high, right is bit 0
    typedef struct packed {
        logic [3:0] unused;
        logic       coin;
        logic       start;
        logic [5:0] buttons;
        logic       up;
        logic       down;
        logic       left;
        logic       right;
    } joy_word_t;

endpackage
